/* dcache_cfg.svh */
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Address split: tag | index | offset
`define DCACHE_ADDR_W      32
`define DCACHE_TAG_W       20
`define DCACHE_INDEX_W     8
`define DCACHE_OFFSET_W    4

`define DCACHE_WORD_W      32
`define DCACHE_WAYS        2
`define DCACHE_LINE_WORDS  4

// Sets per way
`define DCACHE_SETS        (1 << `DCACHE_INDEX_W)

`endif

/* dcache_cpu_pkg.sv */
`default_nettype none

`include "dcache_cfg.svh"

package dcache_cpu_pkg;

    // Byte address from the CPU
    typedef logic [`DCACHE_ADDR_W-1:0] addr_t;

    // Address fields
    typedef logic [`DCACHE_TAG_W-1:0] tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0] index_t;
    typedef logic [`DCACHE_OFFSET_W-1:0] offset_t;

    // One data word and its byte enables
    typedef logic [`DCACHE_WORD_W-1:0] word_t;
    typedef logic [`DCACHE_WORD_W/8-1:0] strb_t;

endpackage

`default_nettype wire

/* dcache_mem_pkg.sv */
`default_nettype none

`include "dcache_cfg.svh"

package dcache_mem_pkg;

    // Whole line, word 0 in the low bits
    typedef logic [`DCACHE_LINE_WORDS*`DCACHE_WORD_W-1:0] line_t;

    // One bit per way
    typedef logic [`DCACHE_WAYS-1:0] way_sel_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL
    } ctrl_state_t;

endpackage

`default_nettype wire

/* dcache_req_stage.sv */
`default_nettype none
`timescale 1ns/1ps

`include "dcache_cfg.svh"

module dcache_req_stage
    import dcache_cpu_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  logic    valid,
    input  logic    op,
    input  addr_t   addr,
    input  strb_t   wstrb,
    input  word_t   wdata,
    input  logic    ready,
    output logic    addr_ok,
    output logic    req_fire,
    output logic    rd_en,
    output index_t  rd_index,
    output logic    req_op,
    output tag_t    req_tag,
    output index_t  req_index,
    output offset_t req_offset,
    output strb_t   req_wstrb,
    output word_t   req_wdata
);

    assign addr_ok  = valid && ready;
    assign req_fire = addr_ok;

    // Way arrays start their read in the accept cycle
    assign rd_en    = req_fire;
    assign rd_index = addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            req_op <= 1'b0;
        end else if (req_fire) begin
            req_op <= op;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_tag    <= addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
            req_index  <= addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
            req_offset <= addr[`DCACHE_OFFSET_W-1:0];
            req_wstrb  <= wstrb;
            req_wdata  <= wdata;
        end
    end

endmodule

`default_nettype wire

/* dcache_way.sv */
`default_nettype none
`timescale 1ns/1ps

`include "dcache_cfg.svh"

module dcache_way
    import dcache_cpu_pkg::*, dcache_mem_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  logic    rd_en,
    input  index_t  rd_index,
    input  tag_t    req_tag,
    input  index_t  req_index,
    input  offset_t req_offset,
    input  strb_t   req_wstrb,
    input  word_t   req_wdata,
    input  logic    store_en,
    input  logic    refill_en,
    input  line_t   refill_line,
    input  logic    refill_dirty,
    output logic    hit,
    output logic    way_valid,
    output logic    way_dirty,
    output tag_t    way_tag,
    output line_t   way_line
);

    logic  valid_q [`DCACHE_SETS];
    logic  dirty_q [`DCACHE_SETS];
    tag_t  tag_mem [`DCACHE_SETS];
    line_t data_mem [`DCACHE_SETS];

    logic [`DCACHE_OFFSET_W-3:0] word_sel;
    logic                        store_hit;

    assign word_sel  = req_offset[`DCACHE_OFFSET_W-1:2];
    assign store_hit = store_en && hit;
    assign hit       = way_valid && (way_tag == req_tag);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < `DCACHE_SETS; i++) begin
                valid_q[i] <= 1'b0;
                dirty_q[i] <= 1'b0;
            end
        end else if (refill_en) begin
            valid_q[req_index] <= 1'b1;
            dirty_q[req_index] <= refill_dirty;
        end else if (store_hit) begin
            dirty_q[req_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_en) begin
            tag_mem[req_index]  <= req_tag;
            data_mem[req_index] <= refill_line;
        end else if (store_hit) begin
            // Byte merge into the addressed word
            for (int b = 0; b < `DCACHE_WORD_W/8; b++) begin
                if (req_wstrb[b]) begin
                    data_mem[req_index][word_sel*`DCACHE_WORD_W + b*8 +: 8] <=
                        req_wdata[b*8 +: 8];
                end
            end
        end
    end

    // One-cycle read, result held until the next request
    always_ff @(posedge clk) begin
        if (rd_en) begin
            way_valid <= valid_q[rd_index];
            way_dirty <= dirty_q[rd_index];
            way_tag   <= tag_mem[rd_index];
            way_line  <= data_mem[rd_index];
        end
    end

endmodule

`default_nettype wire

/* dcache_lookup.sv */
`default_nettype none
`timescale 1ns/1ps

`include "dcache_cfg.svh"

module dcache_lookup
    import dcache_cpu_pkg::*, dcache_mem_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  way_sel_t hit,
    input  way_sel_t way_valid,
    input  way_sel_t way_dirty,
    input  tag_t     way_tag [`DCACHE_WAYS],
    input  line_t    way_line [`DCACHE_WAYS],
    input  index_t   req_index,
    input  offset_t  req_offset,
    input  logic     lookup_active,
    output logic     cache_hit,
    output word_t    hit_word,
    output way_sel_t victim,
    output logic     victim_dirty,
    output tag_t     victim_tag,
    output line_t    victim_line
);

    // Way 1 was the last hit in this set
    logic last_hit [`DCACHE_SETS];

    logic [`DCACHE_OFFSET_W-3:0] word_sel;

    assign word_sel  = req_offset[`DCACHE_OFFSET_W-1:2];
    assign cache_hit = |hit;

    always_comb begin
        hit_word = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (hit[w]) begin
                hit_word = hit_word | way_line[w][word_sel*`DCACHE_WORD_W +: `DCACHE_WORD_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < `DCACHE_SETS; i++) begin
                last_hit[i] <= 1'b0;
            end
        end else if (lookup_active && cache_hit) begin
            last_hit[req_index] <= hit[1];
        end
    end

    // Invalid first, then clean, then the way not hit last
    always_comb begin
        if (!way_valid[0]) begin
            victim = way_sel_t'(1);
        end else if (!way_valid[1]) begin
            victim = way_sel_t'(2);
        end else if (way_dirty[0] != way_dirty[1]) begin
            victim = way_dirty[0] ? way_sel_t'(2) : way_sel_t'(1);
        end else begin
            victim = last_hit[req_index] ? way_sel_t'(1) : way_sel_t'(2);
        end
    end

    always_comb begin
        victim_dirty = 1'b0;
        victim_tag   = '0;
        victim_line  = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (victim[w]) begin
                victim_dirty = way_valid[w] && way_dirty[w];
                victim_tag   = way_tag[w];
                victim_line  = way_line[w];
            end
        end
    end

endmodule

`default_nettype wire

/* dcache_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

`include "dcache_cfg.svh"

module dcache_ctrl
    import dcache_cpu_pkg::*, dcache_mem_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  logic     req_fire,
    input  logic     req_op,
    input  tag_t     req_tag,
    input  index_t   req_index,
    input  offset_t  req_offset,
    input  strb_t    req_wstrb,
    input  word_t    req_wdata,
    input  logic     cache_hit,
    input  word_t    hit_word,
    input  way_sel_t victim,
    input  logic     victim_dirty,
    input  tag_t     victim_tag,
    input  line_t    victim_line,
    input  logic     rd_rdy,
    input  logic     ret_valid,
    input  line_t    ret_data,
    input  logic     wr_rdy,
    output logic     ready,
    output logic     lookup_active,
    output logic     store_en,
    output way_sel_t refill_way,
    output line_t    refill_line,
    output logic     refill_dirty,
    output logic     data_ok,
    output word_t    rdata,
    output logic     rd_req,
    output addr_t    rd_addr,
    output logic     wr_req,
    output addr_t    wr_addr,
    output line_t    wr_data
);

    ctrl_state_t state;
    ctrl_state_t next_state;

    // Miss buffer
    way_sel_t mb_way;
    logic     mb_dirty;
    tag_t     mb_tag;
    line_t    mb_line;

    logic [`DCACHE_OFFSET_W-3:0] word_sel;
    logic                        refill_fire;

    assign word_sel    = req_offset[`DCACHE_OFFSET_W-1:2];
    assign refill_fire = (state == REFILL) && ret_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (req_fire) next_state = LOOKUP;
            LOOKUP:  next_state = cache_hit ? IDLE : MISS;
            // Clean victims skip the write-back
            MISS:    if (!mb_dirty || wr_rdy) next_state = REPLACE;
            REPLACE: if (rd_rdy) next_state = REFILL;
            REFILL:  if (ret_valid) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == LOOKUP && !cache_hit) begin
            mb_way   <= victim;
            mb_dirty <= victim_dirty;
            mb_tag   <= victim_tag;
            mb_line  <= victim_line;
        end
    end

    assign ready         = (state == IDLE);
    assign lookup_active = (state == LOOKUP);
    assign store_en      = (state == LOOKUP) && req_op;

    assign wr_req  = (state == MISS) && mb_dirty;
    assign wr_addr = {mb_tag, req_index, {`DCACHE_OFFSET_W{1'b0}}};
    assign wr_data = mb_line;

    assign rd_req  = (state == REPLACE);
    assign rd_addr = {req_tag, req_index, {`DCACHE_OFFSET_W{1'b0}}};

    // Returned line with the pending store bytes on top
    always_comb begin
        refill_line = ret_data;
        if (req_op) begin
            for (int b = 0; b < `DCACHE_WORD_W/8; b++) begin
                if (req_wstrb[b]) begin
                    refill_line[word_sel*`DCACHE_WORD_W + b*8 +: 8] = req_wdata[b*8 +: 8];
                end
            end
        end
    end

    assign refill_way   = refill_fire ? mb_way : '0;
    assign refill_dirty = req_op;

    assign data_ok = ((state == LOOKUP) && cache_hit) || refill_fire;
    assign rdata   = (state == REFILL) ?
                     ret_data[word_sel*`DCACHE_WORD_W +: `DCACHE_WORD_W] : hit_word;

endmodule

`default_nettype wire

/* dcache_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "dcache_cfg.svh"

module dcache_top
    import dcache_cpu_pkg::*, dcache_mem_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  logic  valid,
    input  logic  op,
    input  addr_t addr,
    input  strb_t wstrb,
    input  word_t wdata,
    output logic  addr_ok,
    output logic  data_ok,
    output word_t rdata,
    output logic  rd_req,
    output addr_t rd_addr,
    input  logic  rd_rdy,
    input  logic  ret_valid,
    input  line_t ret_data,
    output logic  wr_req,
    output addr_t wr_addr,
    output line_t wr_data,
    input  logic  wr_rdy
);

    logic     ready, req_fire, rd_en, req_op;
    index_t   rd_index, req_index;
    tag_t     req_tag;
    offset_t  req_offset;
    strb_t    req_wstrb;
    word_t    req_wdata;

    way_sel_t way_hit, way_valid, way_dirty, refill_way, victim;
    tag_t     way_tag [`DCACHE_WAYS];
    line_t    way_line [`DCACHE_WAYS];

    logic     lookup_active, store_en, refill_dirty, cache_hit, victim_dirty;
    line_t    refill_line, victim_line;
    word_t    hit_word;
    tag_t     victim_tag;

    dcache_req_stage u_req_stage (
        .clk, .resetn, .valid, .op, .addr, .wstrb, .wdata, .ready,
        .addr_ok, .req_fire, .rd_en, .rd_index, .req_op, .req_tag,
        .req_index, .req_offset, .req_wstrb, .req_wdata
    );

    for (genvar g = 0; g < `DCACHE_WAYS; g++) begin : g_way
        dcache_way u_way (
            .clk, .resetn, .rd_en, .rd_index, .req_tag, .req_index,
            .req_offset, .req_wstrb, .req_wdata, .store_en,
            .refill_en    (refill_way[g]),
            .refill_line, .refill_dirty,
            .hit          (way_hit[g]),
            .way_valid    (way_valid[g]),
            .way_dirty    (way_dirty[g]),
            .way_tag      (way_tag[g]),
            .way_line     (way_line[g])
        );
    end

    dcache_lookup u_lookup (
        .clk, .resetn, .hit(way_hit), .way_valid, .way_dirty, .way_tag, .way_line,
        .req_index, .req_offset, .lookup_active, .cache_hit, .hit_word,
        .victim, .victim_dirty, .victim_tag, .victim_line
    );

    dcache_ctrl u_ctrl (
        .clk, .resetn, .req_fire, .req_op, .req_tag, .req_index, .req_offset,
        .req_wstrb, .req_wdata, .cache_hit, .hit_word, .victim, .victim_dirty,
        .victim_tag, .victim_line, .rd_rdy, .ret_valid, .ret_data, .wr_rdy,
        .ready, .lookup_active, .store_en, .refill_way, .refill_line,
        .refill_dirty, .data_ok, .rdata, .rd_req, .rd_addr, .wr_req,
        .wr_addr, .wr_data
    );

endmodule

`default_nettype wire

/* dcache_properties.sv */
`default_nettype none
`timescale 1ns/1ps

module dcache_properties (
    input logic clk,
    input logic resetn,
    input logic valid,
    input logic addr_ok,
    input logic data_ok,
    input logic ready,
    input logic rd_req,
    input logic rd_rdy,
    input logic wr_req,
    input logic wr_rdy
);

    // Number of failed assertions
    int fail_count = 0;

    no_dual_req: assert property (@(posedge clk) disable iff (!resetn)
        !(rd_req && wr_req))
    else begin
        fail_count++;
        $error("read and write requests high together");
    end

    rd_req_held: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req)
    else begin
        fail_count++;
        $error("rd_req dropped before rd_rdy");
    end

    wr_req_held: assert property (@(posedge clk) disable iff (!resetn)
        wr_req && !wr_rdy |=> wr_req)
    else begin
        fail_count++;
        $error("wr_req dropped before wr_rdy");
    end

    addr_ok_needs_valid: assert property (@(posedge clk) disable iff (!resetn)
        addr_ok |-> valid)
    else begin
        fail_count++;
        $error("addr_ok without valid");
    end

    // ready is high exactly in IDLE
    no_data_ok_in_idle: assert property (@(posedge clk) disable iff (!resetn)
        !(data_ok && ready))
    else begin
        fail_count++;
        $error("data_ok while idle");
    end

endmodule

bind dcache_top dcache_properties u_props (
    .clk, .resetn, .valid, .addr_ok, .data_ok, .ready,
    .rd_req, .rd_rdy, .wr_req, .wr_rdy
);

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic resetn
);

    localparam realtime HALF_PERIOD = 20ns;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

`default_nettype wire

/* tb_dcache.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_dcache
    import dcache_cpu_pkg::*, dcache_mem_pkg::*;
();

    localparam int WAIT_LIMIT = 200;
    localparam logic [31:0] SEED = 32'h1c967910;

    logic  clk, resetn;
    logic  valid, op, addr_ok, data_ok;
    addr_t addr, rd_addr, wr_addr;
    strb_t wstrb;
    word_t wdata, rdata;
    logic  rd_req, rd_rdy, ret_valid, wr_req, wr_rdy;
    line_t ret_data, wr_data;

    // Backing store and the CPU-visible image
    line_t mem_lines [addr_t];
    word_t ref_words [addr_t];

    int          rd_count = 0;
    int          wr_count = 0;
    addr_t       last_rd_addr, last_wr_addr;
    line_t       last_wr_data;
    int unsigned rd_dly [64];
    int unsigned wr_dly [64];

    tb_clock_gen u_clock (.clk, .resetn);

    dcache_top UUT (
        .clk, .resetn, .valid, .op, .addr, .wstrb, .wdata, .addr_ok, .data_ok,
        .rdata, .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_data, .wr_req,
        .wr_addr, .wr_data, .wr_rdy
    );

    function automatic addr_t word_key(input addr_t a);
        return {a[31:2], 2'b00};
    endfunction

    function automatic word_t pattern_word(input addr_t a);
        addr_t wa;
        wa = word_key(a);
        return (wa * 32'h9e3779b1) ^ {wa[15:0], wa[31:16]} ^ 32'hc3a55a3c;
    endfunction

    function automatic line_t mem_read(input addr_t la);
        line_t l;
        if (mem_lines.exists(la)) begin
            return mem_lines[la];
        end
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = pattern_word(la + w*4);
        end
        return l;
    endfunction

    function automatic word_t expect_word(input addr_t a);
        if (ref_words.exists(word_key(a))) begin
            return ref_words[word_key(a)];
        end
        return pattern_word(a);
    endfunction

    function automatic line_t expect_line(input addr_t la);
        line_t l;
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = expect_word(la + w*4);
        end
        return l;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input strb_t s, input word_t d);
        word_t r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                r[b*8 +: 8] = d[b*8 +: 8];
            end
        end
        return r;
    endfunction

    function automatic addr_t make_addr(input tag_t t, input index_t i, input offset_t o);
        return {t, i, o};
    endfunction

    task automatic compare(input string name, input logic [127:0] exp, input logic [127:0] act);
        if (exp !== act) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            $display("TEST FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out waiting for %s", what);
        $display("TEST FAIL");
        $fatal(1, "wait timed out");
    endtask

    // Memory read port, line returned the cycle after the handshake
    initial begin : read_port
        rd_rdy = 1'b0;
        ret_valid = 1'b0;
        ret_data = '0;
        forever begin
            @(posedge clk);
            if (rd_req === 1'b1) begin
                repeat (rd_dly[rd_count % 64]) @(posedge clk);
                rd_rdy <= 1'b1;
                @(posedge clk);
                rd_rdy <= 1'b0;
                last_rd_addr = rd_addr;
                rd_count++;
                ret_valid <= 1'b1;
                ret_data <= mem_read(rd_addr);
                @(posedge clk);
                ret_valid <= 1'b0;
            end
        end
    end

    initial begin : write_port
        wr_rdy = 1'b0;
        forever begin
            @(posedge clk);
            if (wr_req === 1'b1) begin
                repeat (wr_dly[wr_count % 64]) @(posedge clk);
                wr_rdy <= 1'b1;
                @(posedge clk);
                wr_rdy <= 1'b0;
                mem_lines[wr_addr] = wr_data;
                last_wr_addr = wr_addr;
                last_wr_data = wr_data;
                wr_count++;
            end
        end
    end

    // lat counts cycles from acceptance to data_ok
    task automatic cpu_access(input logic wr, input addr_t a, input strb_t s, input word_t d,
                              output word_t rd, output int lat);
        int n;
        @(posedge clk);
        valid <= 1'b1;
        op <= wr;
        addr <= a;
        wstrb <= s;
        wdata <= d;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) report_timeout("addr_ok");
        end while (addr_ok !== 1'b1);
        valid <= 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
            if (lat > WAIT_LIMIT) report_timeout("data_ok");
        end while (data_ok !== 1'b1);
        rd = rdata;
    endtask

    task automatic read_and_check(input string name, input addr_t a, output int lat);
        word_t got;
        cpu_access(1'b0, a, 4'b0000, 32'h0, got, lat);
        compare(name, expect_word(a), got);
    endtask

    task automatic write_word(input addr_t a, input strb_t s, input word_t d, output int lat);
        word_t ignored;
        cpu_access(1'b1, a, s, d, ignored, lat);
        ref_words[word_key(a)] = merge_bytes(expect_word(a), s, d);
    endtask

    task automatic read_miss();
        int lat;
        addr_t a;
        a = make_addr(20'h00012, 8'h03, 4'h4);
        read_and_check("read_miss", a, lat);
        compare("read_miss rd count", 1, rd_count);
        compare("read_miss wr count", 0, wr_count);
        compare("read_miss rd_addr", make_addr(20'h00012, 8'h03, 4'h0), last_rd_addr);
    endtask

    task automatic read_hit();
        int lat;
        int rd_before;
        rd_before = rd_count;
        read_and_check("read_hit", make_addr(20'h00012, 8'h03, 4'h4), lat);
        compare("read_hit latency", 1, lat);
        compare("read_hit rd count", rd_before, rd_count);
    endtask

    task automatic write_hit();
        int lat;
        int rd_before;
        addr_t a;
        a = make_addr(20'h00012, 8'h03, 4'h4);
        rd_before = rd_count;
        write_word(a, 4'b0101, 32'hdeadbeef, lat);
        compare("write_hit latency", 1, lat);
        read_and_check("write_hit readback", a, lat);
        compare("write_hit rd count", rd_before, rd_count);
    endtask

    task automatic write_miss();
        int lat;
        int rd_before;
        addr_t a;
        a = make_addr(20'h00055, 8'h07, 4'hc);
        rd_before = rd_count;
        write_word(a, 4'b0011, 32'h1234abcd, lat);
        compare("write_miss rd count", rd_before + 1, rd_count);
        read_and_check("write_miss readback", a, lat);
        read_and_check("write_miss other word", make_addr(20'h00055, 8'h07, 4'h0), lat);
    endtask

    task automatic dirty_evict();
        int lat;
        int wr_before;
        addr_t a1;
        a1 = make_addr(20'h00200, 8'h20, 4'h4);
        write_word(make_addr(20'h00100, 8'h20, 4'h8), 4'b1111, 32'h11112222, lat);
        write_word(a1, 4'b1100, 32'hbeef0000, lat);
        // Way 1 hit first, so the way 0 hit has to move the last-hit bit
        read_and_check("evict hit way1", a1, lat);
        compare("evict hit way1 latency", 1, lat);
        read_and_check("evict hit way0", make_addr(20'h00100, 8'h20, 4'h8), lat);
        compare("evict hit latency", 1, lat);
        wr_before = wr_count;
        read_and_check("evict third tag", make_addr(20'h00300, 8'h20, 4'h0), lat);
        compare("evict wr count", wr_before + 1, wr_count);
        compare("evict wr_addr", make_addr(20'h00200, 8'h20, 4'h0), last_wr_addr);
        compare("evict wr_data", expect_line(make_addr(20'h00200, 8'h20, 4'h0)), last_wr_data);
        read_and_check("evict return", a1, lat);
    endtask

    task automatic random_mix();
        int lat;
        addr_t a;
        for (int i = 0; i < 60; i++) begin
            a = make_addr(20'h0a000 + $urandom % 4, 8'h40 + $urandom % 4, ($urandom % 4) * 4);
            if ($urandom % 2) begin
                write_word(a, strb_t'($urandom), word_t'($urandom), lat);
            end else begin
                read_and_check($sformatf("random_mix op %0d", i), a, lat);
            end
        end
    endtask

    initial begin
        int n;
        valid = 1'b0;
        op = 1'b0;
        addr = '0;
        wstrb = '0;
        wdata = '0;
        void'($urandom(SEED));
        for (int i = 0; i < 64; i++) begin
            rd_dly[i] = $urandom % 6;
            wr_dly[i] = $urandom % 4;
        end
        n = 0;
        while (resetn !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) report_timeout("reset release");
        end
        read_miss();
        read_hit();
        write_hit();
        write_miss();
        dirty_evict();
        random_mix();
        repeat (2) @(posedge clk);
        if (UUT.u_props.fail_count != 0) begin
            $display("%0d assertion failures", UUT.u_props.fail_count);
            $display("TEST FAIL");
            $fatal(1, "assertion check failed");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
dcache_cpu_pkg.sv
dcache_mem_pkg.sv
dcache_req_stage.sv
dcache_way.sv
dcache_lookup.sv
dcache_ctrl.sv
dcache_top.sv
dcache_properties.sv
tb_clock_gen.sv
tb_dcache.sv
